// File: verilog/lt_inverse_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed-point types, AXI response codes
// and the register map of the inverter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package lt_inverse_pkg;

	// entries are Q7.8 two's complement
	localparam int FIX_W = 16;
	localparam int FRAC = 8;
	localparam int ACC_W = 32;

	typedef logic signed [FIX_W-1:0] fix_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	// one quotient bit per step over the shifted numerator
	localparam int DIV_ITER = ACC_W + FRAC;
	localparam int MULT_LAT = 2;

	localparam int AXI_AW = 12;
	localparam int AXI_DW = 32;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// control and status registers
	localparam logic [AXI_AW-1:0] REG_CTRL = 12'h000;
	localparam logic [AXI_AW-1:0] REG_STATUS = 12'h004;

	// matrix windows, entry (i,j) at word i*N+j
	localparam logic [AXI_AW-1:0] L_BASE = 12'h100;
	localparam logic [AXI_AW-1:0] X_BASE = 12'h200;

endpackage

`default_nettype wire

// File: verilog/ifc_array_op.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// issue/done link to an arithmetic unit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

interface ifc_array_op #(
	type a_t = logic,
	type b_t = logic,
	type r_t = logic
) (
	input logic ifc_lt_inverse,
	input logic arst_n
);

	logic en;
	logic issue;
	a_t opa;
	b_t opb;
	r_t result;
	logic done;

	// the sequencer side
	modport client (
		input ifc_lt_inverse, arst_n, result, done,
		output en, issue, opa, opb
	);

	modport unit (
		input ifc_lt_inverse, arst_n, en, issue, opa, opb,
		output result, done
	);

endinterface

`default_nettype wire

// File: verilog/array_mult.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lane-parallel pipelined multiplier
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module array_mult import lt_inverse_pkg::*; #(
	type a_t = fix_t,
	type b_t = fix_t [1:0],
	type r_t = acc_t [1:0]
) (
	ifc_array_op.unit op
);

	localparam int LANES = $bits(b_t) / FIX_W;

	r_t prod_q;
	r_t res_q;
	logic v1_q;
	logic v2_q;
	logic [1:0] inflight_q;

	// valid bits follow the data through both stages
	always_ff @(posedge op.ifc_lt_inverse or negedge op.arst_n) begin
		if (!op.arst_n) begin
			v1_q <= 1'b0;
			v2_q <= 1'b0;
		end else if (op.en) begin
			v1_q <= op.issue;
			v2_q <= v1_q;
		end
	end

	always_ff @(posedge op.ifc_lt_inverse) begin
		if (op.en) begin
			for (int i = 0; i < LANES; i++) begin
				prod_q[i] <= acc_t'(op.opa) * acc_t'($signed(op.opb[i]));
				// floor of the product in Q.8
				res_q[i] <= $signed(prod_q[i]) >>> FRAC;
			end
		end
	end

	assign op.result = res_q;
	assign op.done = v2_q && op.en;

	// count of items between issue and done
	always_ff @(posedge op.ifc_lt_inverse or negedge op.arst_n) begin
		if (!op.arst_n) begin
			inflight_q <= '0;
		end else begin
			inflight_q <= inflight_q + 2'(op.issue && op.en) - 2'(op.done);
		end
	end

	a_done_has_issue: assert property (@(posedge op.ifc_lt_inverse) disable iff (!op.arst_n)
		op.done |-> inflight_q != 2'd0);

endmodule

`default_nettype wire

// File: verilog/array_div.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lane-parallel sequential divider
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module array_div import lt_inverse_pkg::*; #(
	type a_t = acc_t [1:0],
	type b_t = fix_t,
	type r_t = fix_t [1:0]
) (
	ifc_array_op.unit op
);

	localparam int LANES = $bits(r_t) / FIX_W;
	localparam int Q_W = ACC_W + FRAC;

	logic busy_q;
	logic [$clog2(DIV_ITER+1)-1:0] cnt_q;
	logic done_q;
	logic [FIX_W-1:0] dvs_q;
	logic [LANES-1:0] neg_q;
	logic [Q_W-1:0] q_q [LANES];
	logic [FIX_W-1:0] rem_q [LANES];
	logic [Q_W-1:0] q_d [LANES];
	logic [FIX_W-1:0] rem_d [LANES];
	r_t res_q;

	// one restoring step per lane
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			logic [FIX_W:0] sh;
			sh = {rem_q[i], q_q[i][Q_W-1]};
			if (sh >= {1'b0, dvs_q}) begin
				rem_d[i] = FIX_W'(sh - {1'b0, dvs_q});
				q_d[i] = {q_q[i][Q_W-2:0], 1'b1};
			end else begin
				rem_d[i] = sh[FIX_W-1:0];
				q_d[i] = {q_q[i][Q_W-2:0], 1'b0};
			end
		end
	end

	always_ff @(posedge op.ifc_lt_inverse or negedge op.arst_n) begin
		if (!op.arst_n) begin
			busy_q <= 1'b0;
			cnt_q <= '0;
			done_q <= 1'b0;
		end else if (op.en) begin
			done_q <= 1'b0;
			if (!busy_q && op.issue) begin
				busy_q <= 1'b1;
				cnt_q <= '0;
			end else if (busy_q) begin
				if (cnt_q == DIV_ITER) begin
					busy_q <= 1'b0;
					done_q <= 1'b1;
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge op.ifc_lt_inverse) begin
		if (op.en) begin
			if (!busy_q && op.issue) begin
				dvs_q <= op.opb;
				for (int i = 0; i < LANES; i++) begin
					// magnitude of the numerator, shifted by FRAC
					neg_q[i] <= op.opa[i][ACC_W-1];
					q_q[i] <= {(op.opa[i][ACC_W-1] ? -op.opa[i] : op.opa[i]),
						{FRAC{1'b0}}};
					rem_q[i] <= '0;
				end
			end else if (busy_q && cnt_q != DIV_ITER) begin
				for (int i = 0; i < LANES; i++) begin
					q_q[i] <= q_d[i];
					rem_q[i] <= rem_d[i];
				end
			end else if (busy_q) begin
				// truncation toward zero, wrapped to the entry width
				for (int i = 0; i < LANES; i++) begin
					res_q[i] <= neg_q[i] ? -q_q[i][FIX_W-1:0] : q_q[i][FIX_W-1:0];
				end
			end
		end
	end

	assign op.result = res_q;
	assign op.done = done_q;

	a_issue_idle: assert property (@(posedge op.ifc_lt_inverse) disable iff (!op.arst_n)
		op.issue && op.en |-> !busy_q);

endmodule

`default_nettype wire

// File: verilog/lt_inverse.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// forward-substitution sequencer with
// the L and X storage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module lt_inverse import lt_inverse_pkg::*; #(
	parameter int N = 4,
	type fix_vec_t = fix_t [N-1:0],
	type acc_vec_t = acc_t [N-1:0]
) (
	input logic ifc_lt_inverse,
	input logic arst_n,
	input logic start,
	input logic l_we,
	input logic [$clog2(N*N)-1:0] l_idx,
	input fix_t l_wdata,
	output fix_t l_rdata,
	output fix_t x_rdata,
	output logic busy,
	output logic done,
	output logic fault,
	ifc_array_op.client mult,
	ifc_array_op.client div
);

	localparam int ROW_W = $clog2(N) + 1;

	typedef enum logic [1:0] {S_IDLE, S_MUL, S_DIV, S_WAIT} state_t;

	state_t state_q;
	fix_t l_mem [N*N];
	fix_t x_mem [N*N];
	acc_vec_t acc_q;
	fix_vec_t xrow;
	logic [ROW_W-1:0] row_q;
	logic [ROW_W-1:0] iss_q;
	logic [ROW_W-1:0] rcv_q;
	logic diag_ok;
	logic busy_q;
	logic done_q;
	logic fault_q;

	always_comb begin
		diag_ok = 1'b1;
		for (int i = 0; i < N; i++) begin
			if (l_mem[i*N+i] <= 0) diag_ok = 1'b0;
		end
	end

	// row k of X, the operand for the k-th multiply
	always_comb begin
		for (int j = 0; j < N; j++) begin
			xrow[j] = x_mem[int'(iss_q)*N+j];
		end
	end

	assign l_rdata = l_mem[l_idx];
	assign x_rdata = x_mem[l_idx];

	assign mult.en = busy_q;
	assign mult.issue = state_q == S_MUL && iss_q < row_q;
	assign mult.opa = l_mem[int'(row_q)*N+int'(iss_q)];
	assign mult.opb = xrow;

	assign div.en = busy_q;
	assign div.issue = state_q == S_DIV;
	assign div.opa = acc_q;
	assign div.opb = l_mem[int'(row_q)*N+int'(row_q)];

	always_ff @(posedge ifc_lt_inverse or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= S_IDLE;
			row_q <= '0;
			iss_q <= '0;
			rcv_q <= '0;
			busy_q <= 1'b0;
			done_q <= 1'b0;
			fault_q <= 1'b0;
			for (int i = 0; i < N*N; i++) begin
				l_mem[i] <= '0;
				x_mem[i] <= '0;
			end
		end else begin
			if (l_we) l_mem[l_idx] <= l_wdata;
			case (state_q)
				S_IDLE: begin
					if (start) begin
						done_q <= 1'b0;
						fault_q <= !diag_ok;
						if (diag_ok) begin
							busy_q <= 1'b1;
							state_q <= S_MUL;
							row_q <= '0;
							iss_q <= '0;
							rcv_q <= '0;
						end
					end
				end
				S_MUL: begin
					if (mult.issue) iss_q <= iss_q + 1'b1;
					if (mult.done) rcv_q <= rcv_q + 1'b1;
					// all products of the row are subtracted
					if (rcv_q == row_q) state_q <= S_DIV;
				end
				S_DIV: state_q <= S_WAIT;
				S_WAIT: begin
					if (div.done) begin
						for (int j = 0; j < N; j++) begin
							x_mem[int'(row_q)*N+j] <= (j <= int'(row_q)) ? div.result[j] : '0;
						end
						iss_q <= '0;
						rcv_q <= '0;
						if (row_q == ROW_W'(N-1)) begin
							busy_q <= 1'b0;
							done_q <= 1'b1;
							state_q <= S_IDLE;
						end else begin
							row_q <= row_q + 1'b1;
							state_q <= S_MUL;
						end
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// numerators start from the identity row and lose one product each
	always_ff @(posedge ifc_lt_inverse) begin
		if ((state_q == S_IDLE && start) || (state_q == S_WAIT && div.done)) begin
			for (int j = 0; j < N; j++) begin
				if (state_q == S_IDLE) begin
					acc_q[j] <= (j == 0) ? acc_t'(1 << FRAC) : '0;
				end else begin
					acc_q[j] <= (j == int'(row_q) + 1) ? acc_t'(1 << FRAC) : '0;
				end
			end
		end else if (state_q == S_MUL && mult.done) begin
			for (int j = 0; j < N; j++) begin
				acc_q[j] <= acc_q[j] - mult.result[j];
			end
		end
	end

	assign busy = busy_q;
	assign done = done_q;
	assign fault = fault_q;

	a_div_pos: assert property (@(posedge ifc_lt_inverse) disable iff (!arst_n)
		div.issue |-> $signed(div.opb) > 0);

endmodule

`default_nettype wire

// File: verilog/lt_inverse_axil.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave and register decoder
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module lt_inverse_axil import lt_inverse_pkg::*; #(
	parameter int N = 4
) (
	input logic ifc_lt_inverse,
	input logic arst_n,
	input logic [AXI_AW-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [AXI_DW-1:0] wdata,
	input logic [AXI_DW/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [AXI_AW-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [AXI_DW-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic start,
	output logic l_we,
	output logic [$clog2(N*N)-1:0] l_idx,
	output fix_t l_wdata,
	input fix_t l_rdata,
	input fix_t x_rdata,
	input logic busy,
	input logic done,
	input logic fault
);

	localparam int IDX_W = $clog2(N*N);

	logic aw_have;
	logic w_have;
	logic rd_pend;
	logic start_pend;
	logic wr_fire;
	logic [AXI_AW-1:0] aw_q;
	logic [AXI_AW-1:0] ar_q;
	logic [AXI_DW-1:0] w_q;
	logic [AXI_DW/8-1:0] ws_q;

	function automatic logic in_win(logic [AXI_AW-1:0] a, logic [AXI_AW-1:0] base);
		return a >= base && a < base + AXI_AW'(4*N*N);
	endfunction

	function automatic logic [IDX_W-1:0] word(logic [AXI_AW-1:0] a, logic [AXI_AW-1:0] base);
		logic [AXI_AW-1:0] off;
		off = (a - base) >> 2;
		return off[IDX_W-1:0];
	endfunction

	// a write needs both halves and waits while a read holds the index
	assign wr_fire = aw_have && w_have && !bvalid && !rd_pend && !arready;

	always_ff @(posedge ifc_lt_inverse or negedge arst_n) begin
		if (!arst_n) begin
			awready <= 1'b0;
			wready <= 1'b0;
			arready <= 1'b0;
			aw_have <= 1'b0;
			w_have <= 1'b0;
			rd_pend <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			start_pend <= 1'b0;
			start <= 1'b0;
			l_we <= 1'b0;
		end else begin
			awready <= awvalid && !awready && !aw_have && !bvalid;
			wready <= wvalid && !wready && !w_have && !bvalid;
			arready <= arvalid && !arready && !rd_pend && !rvalid && !(aw_have && w_have);
			l_we <= 1'b0;
			start <= bvalid && bready && start_pend;
			if (awvalid && awready) aw_have <= 1'b1;
			if (wvalid && wready) w_have <= 1'b1;
			if (wr_fire) begin
				aw_have <= 1'b0;
				w_have <= 1'b0;
				bvalid <= 1'b1;
				start_pend <= 1'b0;
				bresp <= RESP_SLVERR;
				if (aw_q == REG_CTRL) begin
					bresp <= RESP_OKAY;
					start_pend <= w_q[0] && ws_q[0];
				end else if (in_win(aw_q, L_BASE) && ws_q[1:0] == 2'b11 && !busy) begin
					// only the lower triangle holds entries of L
					if (word(aw_q, L_BASE) / N >= word(aw_q, L_BASE) % N) begin
						bresp <= RESP_OKAY;
						l_we <= 1'b1;
					end
				end
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (arvalid && arready) rd_pend <= 1'b1;
			if (rd_pend && !rvalid) begin
				rd_pend <= 1'b0;
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge ifc_lt_inverse) begin
		if (awvalid && awready) aw_q <= awaddr;
		if (wvalid && wready) begin
			w_q <= wdata;
			ws_q <= wstrb;
		end
		if (arvalid && arready) begin
			ar_q <= araddr;
			// X_BASE sits a whole number of windows above L_BASE so one offset indexes both
			l_idx <= word(araddr, L_BASE);
		end else if (wr_fire) begin
			l_idx <= word(aw_q, L_BASE);
			l_wdata <= fix_t'(w_q[FIX_W-1:0]);
		end
		if (rd_pend && !rvalid) begin
			rresp <= RESP_OKAY;
			if (ar_q == REG_CTRL) rdata <= '0;
			else if (ar_q == REG_STATUS) rdata <= AXI_DW'({fault, done, busy});
			else if (in_win(ar_q, L_BASE)) rdata <= AXI_DW'(l_rdata);
			else if (in_win(ar_q, X_BASE)) rdata <= AXI_DW'(x_rdata);
			else begin
				rdata <= '0;
				rresp <= RESP_SLVERR;
			end
		end
	end

	a_bvalid_hold: assert property (@(posedge ifc_lt_inverse) disable iff (!arst_n)
		bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

// File: verilog/lt_inverse_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level of the matrix inverter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module lt_inverse_top import lt_inverse_pkg::*; #(
	parameter int N = 4
) (
	input logic ifc_lt_inverse,
	input logic arst_n,
	input logic [AXI_AW-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [AXI_DW-1:0] wdata,
	input logic [AXI_DW/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [AXI_AW-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [AXI_DW-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	typedef fix_t [N-1:0] fix_vec_t;
	typedef acc_t [N-1:0] acc_vec_t;

	logic start;
	logic l_we;
	logic [$clog2(N*N)-1:0] l_idx;
	fix_t l_wdata;
	fix_t l_rdata;
	fix_t x_rdata;
	logic busy;
	logic done;
	logic fault;

	ifc_array_op #(.a_t(fix_t), .b_t(fix_vec_t), .r_t(acc_vec_t))
		mult_if (ifc_lt_inverse, arst_n);
	ifc_array_op #(.a_t(acc_vec_t), .b_t(fix_t), .r_t(fix_vec_t))
		div_if (ifc_lt_inverse, arst_n);

	lt_inverse_axil #(.N(N)) axil_i (.*);

	lt_inverse #(.N(N), .fix_vec_t(fix_vec_t), .acc_vec_t(acc_vec_t)) seq_i (
		.ifc_lt_inverse, .arst_n, .start, .l_we, .l_idx, .l_wdata, .l_rdata,
		.x_rdata, .busy, .done, .fault, .mult(mult_if.client), .div(div_if.client)
	);

	// the shared arithmetic units
	array_mult #(.a_t(fix_t), .b_t(fix_vec_t), .r_t(acc_vec_t)) mult_i (.op(mult_if.unit));
	array_div #(.a_t(acc_vec_t), .b_t(fix_t), .r_t(fix_vec_t)) div_i (.op(div_if.unit));

endmodule

`default_nettype wire

// File: tb/lt_inverse_tb_model.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LFSR, inversion model, compare tasks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef LT_INVERSE_TB_MODEL_SVH
`define LT_INVERSE_TB_MODEL_SVH

// taps 32, 22, 2 and 1 give a maximal-length sequence
function automatic logic [31:0] lfsr_next(logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one LFSR step for each bit taken
function automatic logic [31:0] rand_bits(int n);
	logic [31:0] v;
	v = '0;
	for (int b = 0; b < n; b++) begin
		lfsr_q = lfsr_next(lfsr_q);
		v = {v[30:0], lfsr_q[0]};
	end
	return v;
endfunction

// forward substitution on l_ref, row by row and term by term
function automatic void invert_model();
	int num;
	int prod;
	for (int i = 0; i < N; i++) begin
		for (int j = 0; j < N; j++) begin
			num = (i == j) ? (1 << FRAC) : 0;
			for (int k = 0; k < i; k++) begin
				prod = int'(l_ref[i][k]) * int'(x_ref[k][j]);
				num = num - (prod >>> FRAC);
			end
			// quotient truncates toward zero, then wraps to 16 bits
			if (j > i) begin
				x_ref[i][j] = '0;
			end else begin
				x_ref[i][j] = fix_t'((longint'(num) * (1 << FRAC)) / longint'(l_ref[i][i]));
			end
		end
	end
endfunction

task automatic report_fail(string what);
	$display("%s", what);
	$display("Testbench failed");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic check_fix(string name, fix_t exp, fix_t act);
	if (act !== exp) begin
		report_fail($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
	end
endtask

task automatic check_resp(string name, logic [1:0] exp, logic [1:0] act);
	if (act !== exp) begin
		report_fail($sformatf("ERROR %s: expected resp %b, actual resp %b", name, exp, act));
	end
endtask

task automatic check_word(string name, logic [AXI_DW-1:0] exp, logic [AXI_DW-1:0] act);
	if (act !== exp) begin
		report_fail($sformatf("ERROR %s: expected 0x%08h, actual 0x%08h", name, exp, act));
	end
endtask

`endif

// File: tb/lt_inverse_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the matrix inverter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module lt_inverse_tb import lt_inverse_pkg::*; ();

	localparam int N = 4;
	localparam int MATRICES = 20;
	localparam int AXI_OPS = (MATRICES + 6) * (2 * N * N + 8);
	localparam int CYC_LIMIT = MATRICES * N * (N + DIV_ITER + 10) + 16 * AXI_OPS;

	logic ifc_lt_inverse;
	logic arst_n;
	logic [AXI_AW-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [AXI_DW-1:0] wdata;
	logic [AXI_DW/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXI_AW-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [AXI_DW-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic [31:0] lfsr_q;
	fix_t l_ref [N][N];
	fix_t x_ref [N][N];
	int cyc_cnt = 0;

`include "lt_inverse_tb_model.svh"

	lt_inverse_top #(.N(N)) dut_i (.*);

	initial begin
		ifc_lt_inverse = 1'b0;
		forever #4 ifc_lt_inverse = ~ifc_lt_inverse;
	end

	always @(posedge ifc_lt_inverse) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt == CYC_LIMIT) begin
			report_fail("the DUT hung: the run went past its cycle limit");
		end
	end

	function automatic logic [AXI_AW-1:0] entry_addr(logic [AXI_AW-1:0] base, int i, int j);
		return base + AXI_AW'(4 * (i * N + j));
	endfunction

	// all AXI tasks start and end on a falling edge
	task automatic axil_write(logic [AXI_AW-1:0] addr, logic [AXI_DW-1:0] data,
			output logic [1:0] resp);
		logic aw_hs;
		logic w_hs;
		int stall;
		if (bvalid) report_fail("a write response came without a write request");
		awaddr = addr;
		awvalid = 1'b1;
		wdata = data;
		wstrb = '1;
		wvalid = 1'b1;
		while (awvalid || wvalid) begin
			aw_hs = awvalid && awready;
			w_hs = wvalid && wready;
			@(negedge ifc_lt_inverse);
			if (aw_hs) awvalid = 1'b0;
			if (w_hs) wvalid = 1'b0;
		end
		while (!bvalid) @(negedge ifc_lt_inverse);
		stall = int'(rand_bits(2));
		repeat (stall) @(negedge ifc_lt_inverse);
		if (!bvalid) report_fail("a write response was dropped before bready");
		resp = bresp;
		bready = 1'b1;
		@(negedge ifc_lt_inverse);
		bready = 1'b0;
		if (bvalid) report_fail("a write response was repeated after its handshake");
	endtask

	task automatic axil_read(logic [AXI_AW-1:0] addr, output logic [AXI_DW-1:0] data,
			output logic [1:0] resp);
		logic ar_hs;
		int stall;
		if (rvalid) report_fail("read data came without a read request");
		araddr = addr;
		arvalid = 1'b1;
		while (arvalid) begin
			ar_hs = arready;
			@(negedge ifc_lt_inverse);
			if (ar_hs) arvalid = 1'b0;
		end
		while (!rvalid) @(negedge ifc_lt_inverse);
		stall = int'(rand_bits(2));
		repeat (stall) @(negedge ifc_lt_inverse);
		if (!rvalid) report_fail("read data was dropped before rready");
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		@(negedge ifc_lt_inverse);
		rready = 1'b0;
		if (rvalid) report_fail("read data was repeated after its handshake");
	endtask

	task automatic write_expect(logic [AXI_AW-1:0] addr, logic [AXI_DW-1:0] data,
			logic [1:0] exp_resp, string name);
		logic [1:0] resp;
		axil_write(addr, data, resp);
		check_resp(name, exp_resp, resp);
	endtask

	task automatic read_expect(logic [AXI_AW-1:0] addr, logic [AXI_DW-1:0] exp_data,
			logic [1:0] exp_resp, string name);
		logic [AXI_DW-1:0] data;
		logic [1:0] resp;
		axil_read(addr, data, resp);
		check_resp(name, exp_resp, resp);
		check_word(name, exp_data, data);
	endtask

	// matrix words read back sign-extended
	task automatic read_fix(logic [AXI_AW-1:0] addr, fix_t exp, string name);
		logic [AXI_DW-1:0] data;
		logic [1:0] resp;
		axil_read(addr, data, resp);
		check_resp(name, RESP_OKAY, resp);
		check_fix(name, exp, fix_t'(data[FIX_W-1:0]));
		check_word(name, AXI_DW'(exp), data);
	endtask

	task automatic check_x(string name);
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j < N; j++) begin
				read_fix(entry_addr(X_BASE, i, j), x_ref[i][j],
					$sformatf("%s X[%0d][%0d]", name, i, j));
			end
		end
	endtask

	// diagonals from 0.5 to 4.0, the rest within 2.0 either way
	task automatic load_random_matrix(int m);
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j <= i; j++) begin
				if (i == j) begin
					l_ref[i][j] = fix_t'(128 + int'(rand_bits(10)) % 897);
				end else begin
					l_ref[i][j] = fix_t'(int'(rand_bits(10)) - 512);
				end
				write_expect(entry_addr(L_BASE, i, j), AXI_DW'(l_ref[i][j]), RESP_OKAY,
					$sformatf("matrix %0d load L[%0d][%0d]", m, i, j));
			end
		end
	endtask

	initial begin
		logic [AXI_DW-1:0] st;
		logic [1:0] resp;
		fix_t keep;
		lfsr_q = 32'h178c_2896;
		arst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j < N; j++) begin
				l_ref[i][j] = '0;
				x_ref[i][j] = '0;
			end
		end
		repeat (4) @(posedge ifc_lt_inverse);
		@(negedge ifc_lt_inverse);
		arst_n = 1'b1;

		read_expect(REG_STATUS, '0, RESP_OKAY, "reset status");
		check_x("reset");
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j < N; j++) begin
				read_fix(entry_addr(L_BASE, i, j), '0, $sformatf("reset L[%0d][%0d]", i, j));
			end
		end

		// lower triangle is stored, upper triangle is refused
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j < N; j++) begin
				keep = fix_t'(rand_bits(FIX_W));
				if (j <= i) l_ref[i][j] = keep;
				write_expect(entry_addr(L_BASE, i, j), AXI_DW'(keep),
					(j <= i) ? RESP_OKAY : RESP_SLVERR, $sformatf("write L[%0d][%0d]", i, j));
			end
		end
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j < N; j++) begin
				read_fix(entry_addr(L_BASE, i, j), (j <= i) ? l_ref[i][j] : fix_t'(0),
					$sformatf("read back L[%0d][%0d]", i, j));
			end
		end
		write_expect(REG_STATUS, 32'h7, RESP_SLVERR, "status write");
		write_expect(entry_addr(X_BASE, 0, 0), 32'h100, RESP_SLVERR, "X write");
		write_expect(12'h008, 32'h1, RESP_SLVERR, "unmapped write");
		write_expect(REG_CTRL, 32'h0, RESP_OKAY, "ctrl write without start");
		read_expect(REG_STATUS, '0, RESP_OKAY, "status without start");
		read_expect(REG_CTRL, '0, RESP_OKAY, "ctrl read");
		read_expect(12'h008, '0, RESP_SLVERR, "unmapped read 0x008");
		read_expect(entry_addr(L_BASE, N, 0), '0, RESP_SLVERR, "read past L window");
		read_expect(12'h300, '0, RESP_SLVERR, "unmapped read 0x300");

		for (int m = 0; m < MATRICES; m++) begin
			load_random_matrix(m);
			invert_model();
			write_expect(REG_CTRL, 32'h1, RESP_OKAY, $sformatf("matrix %0d start", m));
			read_expect(REG_STATUS, 32'h1, RESP_OKAY, $sformatf("matrix %0d busy", m));
			// L is locked while the sequencer runs
			keep = l_ref[N-1][0];
			write_expect(entry_addr(L_BASE, N - 1, 0), AXI_DW'(~keep), RESP_SLVERR,
				$sformatf("matrix %0d write while busy", m));
			st = 32'h1;
			while (st != 32'h2) begin
				axil_read(REG_STATUS, st, resp);
				check_resp($sformatf("matrix %0d poll", m), RESP_OKAY, resp);
				if (st != 32'h2) check_word($sformatf("matrix %0d poll", m), 32'h1, st);
			end
			read_fix(entry_addr(L_BASE, N - 1, 0), keep, $sformatf("matrix %0d L kept", m));
			check_x($sformatf("matrix %0d", m));
		end

		// a zero diagonal and then a negative one must fault and leave X alone
		keep = l_ref[1][1];
		write_expect(entry_addr(L_BASE, 1, 1), '0, RESP_OKAY, "zero diagonal load");
		write_expect(REG_CTRL, 32'h1, RESP_OKAY, "zero diagonal start");
		read_expect(REG_STATUS, 32'h4, RESP_OKAY, "zero diagonal status");
		check_x("zero diagonal");
		write_expect(entry_addr(L_BASE, 1, 1), AXI_DW'(keep), RESP_OKAY, "diagonal restore");
		write_expect(entry_addr(L_BASE, N - 1, N - 1), AXI_DW'(fix_t'(-256)), RESP_OKAY,
			"negative diagonal load");
		write_expect(REG_CTRL, 32'h1, RESP_OKAY, "negative diagonal start");
		read_expect(REG_STATUS, 32'h4, RESP_OKAY, "negative diagonal status");
		check_x("negative diagonal");

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+tb
verilog/lt_inverse_pkg.sv
verilog/ifc_array_op.sv
verilog/array_mult.sv
verilog/array_div.sv
verilog/lt_inverse.sv
verilog/lt_inverse_axil.sv
verilog/lt_inverse_top.sv
tb/lt_inverse_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= lt_inverse_tb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
